/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = arb_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* arbiter/arb_multi_rr.sv */
//--------------------------------------------------------------------------
// Zero-latency multi-grant arbiter, fair only while requests are held
// grant_allowed must not exceed max_grants
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module arb_multi_rr #(
  parameter int num_requesters = 8,
  parameter int max_grants = 3,
  localparam int grant_count_width = $clog2(max_grants + 1),
  localparam int index_width = $clog2(num_requesters)
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      enable_priority_update,
  input  logic [num_requesters-1:0]                 request,
  input  logic [grant_count_width-1:0]              grant_allowed,
  output logic [num_requesters-1:0]                 grant,
  // Grants as one-hot vectors, highest priority first
  output logic [max_grants-1:0][num_requesters-1:0] grant_ordered,
  output logic [grant_count_width-1:0]              grant_count,
  output logic [index_width-1:0]                    lowest_prio_index
);

  localparam int request_count_width = $clog2(num_requesters + 1);

  logic [max_grants-1:0][num_requesters-1:0] all_grants;
  logic [num_requesters-1:0]                 lowest_prio;
  logic [num_requesters-1:0]                 lowest_prio_next;
  logic [request_count_width-1:0]            request_count;
  logic                                      priority_update;

  // Candidate grants for every slot, regardless of the current limit
  enc_priority_dynamic #(
    .num_requesters(num_requesters),
    .max_grants(max_grants)
  ) u_enc (
    .request(request),
    .lowest_prio(lowest_prio),
    .results(all_grants)
  );

  //------------------------------------------------------------------------
  // Grant count and ordered grants
  //------------------------------------------------------------------------

  always_comb begin
    request_count = '0;
    for (int i = 0; i < num_requesters; i++) begin
      request_count = request_count + request_count_width'(request[i]);
    end
  end

  // The smaller of the active requests and the configured limit
  assign grant_count = (request_count <= request_count_width'(grant_allowed)) ?
                       grant_count_width'(request_count) : grant_allowed;

  // Only the first grant_count slots survive
  for (genvar i = 0; i < max_grants; i++) begin : gen_grant_ordered
    assign grant_ordered[i] = (grant_count > grant_count_width'(i)) ? all_grants[i] : '0;
  end

  always_comb begin
    grant = '0;
    for (int i = 0; i < max_grants; i++) begin
      grant = grant | grant_ordered[i];
    end
  end

  //------------------------------------------------------------------------
  // Priority state
  //------------------------------------------------------------------------

  // The last granted requester becomes the lowest priority next cycle
  always_comb begin
    lowest_prio_next = lowest_prio;
    for (int i = 0; i < max_grants; i++) begin
      if (grant_count == grant_count_width'(i + 1)) begin
        lowest_prio_next = all_grants[i];
      end
    end
  end

  // A zero limit or an idle cycle leaves the marker where it is
  assign priority_update = enable_priority_update && (|request) && (grant_allowed != '0);

  // Out of reset the top requester is lowest, so requester 0 goes first
  always_ff @(posedge clk) begin
    if (reset) begin
      lowest_prio <= {1'b1, {(num_requesters - 1){1'b0}}};
    end else if (priority_update) begin
      lowest_prio <= lowest_prio_next;
    end
  end

  // Binary form of the marker for status readback
  always_comb begin
    lowest_prio_index = '0;
    for (int i = 0; i < num_requesters; i++) begin
      if (lowest_prio[i]) begin
        lowest_prio_index = index_width'(i);
      end
    end
  end

endmodule

/* arbiter/enc_priority_dynamic.sv */
//--------------------------------------------------------------------------
// Purely combinational, lowest_prio must be one-hot for a correct search
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module enc_priority_dynamic #(
  parameter int num_requesters = 8,
  parameter int max_grants = 3
) (
  input  logic [num_requesters-1:0]                 request,
  input  logic [num_requesters-1:0]                 lowest_prio,
  output logic [max_grants-1:0][num_requesters-1:0] results
);

  // One-hot position of the highest priority requester
  logic [num_requesters-1:0] highest_prio;

  // The highest priority sits one place after the lowest, wrapping at the top
  assign highest_prio = {lowest_prio[num_requesters-2:0], lowest_prio[num_requesters-1]};

  //------------------------------------------------------------------------
  // Circular search
  //------------------------------------------------------------------------

  always_comb begin
    int start_index;
    int scan_index;
    int found;

    // Binary position where the scan begins
    start_index = 0;
    for (int i = 0; i < num_requesters; i++) begin
      if (highest_prio[i]) begin
        start_index = i;
      end
    end

    results = '0;
    found = 0;

    // Walk once around the ring in falling priority order
    for (int k = 0; k < num_requesters; k++) begin
      // Wrap without a modulo, the sum is always below twice the ring size
      if (start_index + k >= num_requesters) begin
        scan_index = start_index + k - num_requesters;
      end else begin
        scan_index = start_index + k;
      end

      // The (found+1)-th active request fills the next result slot
      if (request[scan_index] && (found < max_grants)) begin
        results[found][scan_index] = 1'b1;
        found = found + 1;
      end
    end
  end

endmodule

/* bench/arb_assertions.sv */
//--------------------------------------------------------------------------
// Checks on the arbiter outputs, bound into every arb_multi_rr instance
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module arb_assertions #(
  parameter int num_requesters = 8,
  parameter int max_grants = 3,
  localparam int grant_count_width = $clog2(max_grants + 1)
) (
  input logic                                      clk,
  input logic                                      reset,
  input logic [num_requesters-1:0]                 request,
  input logic [num_requesters-1:0]                 grant,
  input logic [max_grants-1:0][num_requesters-1:0] grant_ordered,
  input logic [grant_count_width-1:0]              grant_count,
  input logic [grant_count_width-1:0]              grant_allowed
);

  // Every ordered slot names one requester or none
  for (genvar i = 0; i < max_grants; i++) begin : gen_slot
    slot_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(grant_ordered[i]))
      else $error("Ordered grant slot %0d has more than one bit set", i);
  end

  // The grant vector agrees with the reported count
  count_matches: assert property (@(posedge clk) disable iff (reset)
    $countones(grant) == int'(grant_count))
    else $error("Grant vector bit count differs from grant_count");

  // Only active requesters are granted
  grant_subset: assert property (@(posedge clk) disable iff (reset)
    (grant & ~request) == '0)
    else $error("Grant given to a requester that is not requesting");

  within_limit: assert property (@(posedge clk) disable iff (reset)
    $countones(grant) <= int'(grant_allowed))
    else $error("More grants than the configured limit");

endmodule

/* bench/arb_tb.sv */
//--------------------------------------------------------------------------
// Self-checking bench for 8 requesters and 3 grants, model steps at negedge
// Requests stay high until granted, so a zero limit lets them pile up
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module arb_tb
  import arb_pkg::*;
();

  localparam int num_requesters = 8;
  localparam int max_grants = 3;
  localparam int grant_count_width = $clog2(max_grants + 1);
  localparam int select_width = $clog2(num_requesters + 1);
  localparam int index_width = $clog2(num_requesters);
  // Random phase dominates, directed phases and drains add a few hundred cycles
  localparam int random_cycles = 2000;
  localparam int timeout_cycles = 6000;

  logic                                      clk;
  logic                                      reset;
  logic [num_requesters-1:0]                 request;
  logic                                      cfg_write;
  cfg_addr_e                                 cfg_addr;
  logic [CFG_DATA_WIDTH-1:0]                 cfg_wdata;
  logic [select_width-1:0]                   stat_select;
  logic                                      stat_clear;
  logic [num_requesters-1:0]                 grant;
  logic [max_grants-1:0][num_requesters-1:0] grant_ordered;
  logic [grant_count_width-1:0]              grant_count;
  logic [CFG_DATA_WIDTH-1:0]                 cfg_rdata;
  logic [STAT_WIDTH-1:0]                     stat_count;

  // Reference model state
  int                        model_lowest;
  int                        model_limit;
  logic                      model_enable;
  logic [STAT_WIDTH-1:0]     model_counts [num_requesters];
  // Expected grant of the current cycle, used to drop granted requests
  logic [num_requesters-1:0] exp_grant;

  int     arb_errors;
  int     cfg_errors;
  int     stat_errors;
  int     directed_errors;
  int     checks;
  int     cycle_count;
  logic   timed_out;
  integer seed;

  // Expected results of the frozen-priority phase
  logic [num_requesters-1:0]                 frozen_grant;
  logic [max_grants-1:0][num_requesters-1:0] frozen_ordered;
  int                                        frozen_count;
  int                                        frozen_last;
  logic [CFG_DATA_WIDTH-1:0]                 frozen_status;
  // Expected count once the limit is clamped to max_grants
  int                                        exp_limited;

  arb_subsystem_top #(
    .num_requesters(num_requesters),
    .max_grants(max_grants)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .request(request),
    .cfg_write(cfg_write),
    .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata),
    .stat_select(stat_select),
    .stat_clear(stat_clear),
    .grant(grant),
    .grant_ordered(grant_ordered),
    .grant_count(grant_count),
    .cfg_rdata(cfg_rdata),
    .stat_count(stat_count)
  );

  bind arb_multi_rr arb_assertions #(
    .num_requesters(num_requesters),
    .max_grants(max_grants)
  ) u_assertions (
    .clk(clk),
    .reset(reset),
    .request(request),
    .grant(grant),
    .grant_ordered(grant_ordered),
    .grant_count(grant_count),
    .grant_allowed(grant_allowed)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------

  // Walk the ring from the slot after the lowest-priority index and take
  // requests in order until the limit is reached
  function automatic void ref_arbitrate(
    input  logic [num_requesters-1:0]                 req,
    input  int                                        limit,
    input  int                                        lowest,
    output logic [num_requesters-1:0]                 exp_vec,
    output logic [max_grants-1:0][num_requesters-1:0] exp_ordered,
    output int                                        exp_count,
    output int                                        last_index
  );
    int pos;
    exp_vec = '0;
    exp_ordered = '0;
    exp_count = 0;
    last_index = lowest;
    for (int k = 1; k <= num_requesters; k++) begin
      pos = (lowest + k) % num_requesters;
      if (req[pos] && (exp_count < limit)) begin
        exp_ordered[exp_count][pos] = 1'b1;
        exp_vec[pos] = 1'b1;
        exp_count++;
        last_index = pos;
      end
    end
  endfunction

  // Compare in mid cycle, then step the model as the next edge will
  always @(negedge clk) begin
    logic [num_requesters-1:0]                 e_grant;
    logic [max_grants-1:0][num_requesters-1:0] e_ordered;
    int                                        e_count;
    int                                        e_last;
    logic [CFG_DATA_WIDTH-1:0]                 e_rdata;
    logic [STAT_WIDTH-1:0]                     e_stat;
    logic [index_width-1:0]                    sel_index;
    if (reset) begin
      model_lowest = num_requesters - 1;
      model_limit = max_grants;
      model_enable = 1'b1;
      exp_grant = '0;
      for (int i = 0; i < num_requesters; i++) begin
        model_counts[i] = '0;
      end
    end else begin
      ref_arbitrate(request, model_limit, model_lowest, e_grant, e_ordered, e_count, e_last);
      exp_grant = e_grant;
      checks++;
      if (grant !== e_grant) begin
        $display("ERR t=%0t grant got %h exp %h", $time, grant, e_grant);
        arb_errors++;
      end
      if (grant_ordered !== e_ordered) begin
        $display("ERR t=%0t grant_ordered got %h exp %h", $time, grant_ordered, e_ordered);
        arb_errors++;
      end
      if (grant_count !== grant_count_width'(e_count)) begin
        $display("ERR t=%0t grant_count got %0d exp %0d", $time, grant_count, e_count);
        arb_errors++;
      end
      case (cfg_addr)
        CFG_GRANT_ALLOWED: e_rdata = CFG_DATA_WIDTH'(model_limit);
        CFG_PRIO_UPDATE:   e_rdata = CFG_DATA_WIDTH'(model_enable);
        CFG_STATUS:        e_rdata = CFG_DATA_WIDTH'(model_lowest);
        default:           e_rdata = '0;
      endcase
      if (cfg_rdata !== e_rdata) begin
        $display("ERR t=%0t cfg_rdata got %h exp %h", $time, cfg_rdata, e_rdata);
        cfg_errors++;
      end
      sel_index = index_width'(stat_select);
      e_stat = (int'(stat_select) < num_requesters) ? model_counts[sel_index] : '0;
      if (stat_count !== e_stat) begin
        $display("ERR t=%0t stat_count got %0d exp %0d", $time, stat_count, e_stat);
        stat_errors++;
      end
      // State that the coming edge will change
      if (model_enable && (request != '0) && (model_limit != 0)) begin
        model_lowest = e_last;
      end
      for (int i = 0; i < num_requesters; i++) begin
        if (stat_clear) begin
          model_counts[i] = '0;
        end else if (e_grant[i]) begin
          model_counts[i] = model_counts[i] + STAT_WIDTH'(1);
        end
      end
      if (cfg_write && (cfg_addr == CFG_GRANT_ALLOWED)) begin
        model_limit = (int'(cfg_wdata) > max_grants) ? max_grants : int'(cfg_wdata);
      end else if (cfg_write && (cfg_addr == CFG_PRIO_UPDATE)) begin
        model_enable = cfg_wdata[0];
      end
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus tasks
  //--------------------------------------------------------------------------

  task automatic write_cfg(input cfg_addr_e addr, input logic [CFG_DATA_WIDTH-1:0] data);
    @(posedge clk);
    cfg_write <= 1'b1;
    cfg_addr <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_write <= 1'b0;
  endtask

  task automatic check_readback(input cfg_addr_e addr, input logic [CFG_DATA_WIDTH-1:0] exp);
    @(posedge clk);
    cfg_addr <= addr;
    @(negedge clk);
    if (cfg_rdata !== exp) begin
      $display("ERR t=%0t cfg_rdata got %0d exp %0d", $time, cfg_rdata, exp);
      directed_errors++;
    end
  endtask

  // Keep dropping granted requests until none are left
  task automatic drain_requests();
    do begin
      @(posedge clk);
      request <= request & ~exp_grant;
    end while ((request & ~exp_grant) != '0);
  endtask

  // Sparse new requests on top of the ones still waiting, with rare limit
  // changes and counter clears mixed in
  task automatic drive_held_requests(input int cycles);
    logic [num_requesters-1:0] fresh;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      fresh = num_requesters'($random(seed)) & num_requesters'($random(seed));
      request <= (request & ~exp_grant) | fresh;
      stat_select <= select_width'({$random(seed)} % (num_requesters + 1));
      stat_clear <= (({$random(seed)} % 128) == 0);
      if (({$random(seed)} % 16) == 0) begin
        cfg_write <= 1'b1;
        cfg_addr <= CFG_GRANT_ALLOWED;
        cfg_wdata <= CFG_DATA_WIDTH'({$random(seed)} % 4);
      end else begin
        cfg_write <= 1'b0;
        cfg_addr <= cfg_addr_e'(2'({$random(seed)} % 3));
      end
    end
    @(posedge clk);
    cfg_write <= 1'b0;
    stat_clear <= 1'b0;
  endtask

  task automatic sweep_stats(input logic expect_zero);
    for (int s = 0; s <= num_requesters; s++) begin
      @(posedge clk);
      stat_select <= select_width'(s);
      @(negedge clk);
      if (expect_zero && (stat_count !== '0)) begin
        $display("ERR t=%0t stat_count[%0d] got %0d exp 0", $time, s, stat_count);
        directed_errors++;
      end
    end
  endtask

  task automatic report_and_finish();
    $display("Error counts: arbitration %0d, config %0d, statistics %0d, directed %0d (%0d cycles)",
             arb_errors, cfg_errors, stat_errors, directed_errors, checks);
    if (timed_out || (arb_errors + cfg_errors + stat_errors + directed_errors) != 0) begin
      $display("ERRORS FOUND");
    end else begin
      $display("NO ERRORS");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
      timed_out = 1'b1;
      report_and_finish();
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------

  initial begin
    seed = 32'h761f0336;
    arb_errors = 0;
    cfg_errors = 0;
    stat_errors = 0;
    directed_errors = 0;
    checks = 0;
    cycle_count = 0;
    timed_out = 1'b0;
    reset = 1'b1;
    request = '0;
    cfg_write = 1'b0;
    cfg_addr = CFG_GRANT_ALLOWED;
    cfg_wdata = '0;
    stat_select = '0;
    stat_clear = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // Reset values, then a full request set from the reset priority
    check_readback(CFG_GRANT_ALLOWED, CFG_DATA_WIDTH'(max_grants));
    check_readback(CFG_PRIO_UPDATE, 8'd1);
    check_readback(CFG_STATUS, 8'd7);
    @(posedge clk);
    request <= '1;
    @(negedge clk);
    if (grant_ordered !== {8'h04, 8'h02, 8'h01}) begin
      $display("ERR t=%0t grant_ordered got %h exp 040201", $time, grant_ordered);
      directed_errors++;
    end
    if (grant_count !== 2'd3) begin
      $display("ERR t=%0t grant_count got %0d exp 3", $time, grant_count);
      directed_errors++;
    end
    drain_requests();

    // Random held requests under changing limits
    drive_held_requests(random_cycles);
    write_cfg(CFG_GRANT_ALLOWED, 8'd3);
    drain_requests();

    // Frozen priority repeats the same grants from the current marker
    write_cfg(CFG_PRIO_UPDATE, 8'd0);
    @(posedge clk);
    request <= 8'b1011_0101;
    cfg_addr <= CFG_STATUS;
    ref_arbitrate(8'b1011_0101, max_grants, model_lowest, frozen_grant, frozen_ordered,
                  frozen_count, frozen_last);
    frozen_status = CFG_DATA_WIDTH'(model_lowest);
    repeat (20) begin
      @(negedge clk);
      if (grant !== frozen_grant) begin
        $display("ERR t=%0t grant got %h exp %h", $time, grant, frozen_grant);
        directed_errors++;
      end
      if (grant_ordered !== frozen_ordered) begin
        $display("ERR t=%0t grant_ordered got %h exp %h", $time, grant_ordered,
                 frozen_ordered);
        directed_errors++;
      end
      if (grant_count !== grant_count_width'(frozen_count)) begin
        $display("ERR t=%0t grant_count got %0d exp %0d", $time, grant_count, frozen_count);
        directed_errors++;
      end
      if (cfg_rdata !== frozen_status) begin
        $display("ERR t=%0t cfg_rdata got %h exp %h", $time, cfg_rdata, frozen_status);
        directed_errors++;
      end
    end
    // One grant cycle with the update enabled moves the marker to the last grant
    write_cfg(CFG_PRIO_UPDATE, 8'd1);
    @(posedge clk);
    cfg_addr <= CFG_STATUS;
    @(negedge clk);
    if (cfg_rdata !== CFG_DATA_WIDTH'(frozen_last)) begin
      $display("ERR t=%0t cfg_rdata got %0d exp %0d", $time, cfg_rdata, frozen_last);
      directed_errors++;
    end
    drain_requests();

    // Oversized limit is clamped
    write_cfg(CFG_GRANT_ALLOWED, 8'd7);
    check_readback(CFG_GRANT_ALLOWED, 8'd3);
    repeat (50) begin
      @(posedge clk);
      request <= (request & ~exp_grant) | num_requesters'($random(seed));
      @(negedge clk);
      exp_limited = ($countones(request) < max_grants) ? $countones(request) : max_grants;
      if (grant_count !== grant_count_width'(exp_limited)) begin
        $display("ERR t=%0t grant_count got %0d exp %0d", $time, grant_count, exp_limited);
        directed_errors++;
      end
    end
    drain_requests();

    // Counter readback, then a group clear
    sweep_stats(1'b0);
    @(posedge clk);
    stat_clear <= 1'b1;
    @(posedge clk);
    stat_clear <= 1'b0;
    sweep_stats(1'b1);

    report_and_finish();
  end

endmodule

/* common/arb_pkg.sv */
//--------------------------------------------------------------------------
// Shared register map and widths of the round-robin scheduler
// Status readback holds the marker index in the low bits of the data word
//--------------------------------------------------------------------------

package arb_pkg;

  // Width of configuration write data and readback data
  localparam int CFG_DATA_WIDTH = 8;

  // Width of each per-requester grant counter, which wraps on overflow
  localparam int STAT_WIDTH = 16;

  //------------------------------------------------------------------------
  // Configuration register map
  //------------------------------------------------------------------------

  // Address 3 is unmapped and reads as zero
  typedef enum logic [1:0] {
    // Number of grants allowed per cycle, clamped to max_grants on write
    CFG_GRANT_ALLOWED = 2'd0,
    // Bit 0 enables the rotation of the priority marker
    CFG_PRIO_UPDATE   = 2'd1,
    // Read only, returns the current lowest-priority requester index
    CFG_STATUS        = 2'd2
  } cfg_addr_e;

endpackage

/* source/arb_config.sv */
//--------------------------------------------------------------------------
// Writes land at the next edge, readback is combinational
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module arb_config
  import arb_pkg::*;
#(
  parameter int num_requesters = 8,
  parameter int max_grants = 3,
  localparam int grant_count_width = $clog2(max_grants + 1),
  localparam int index_width = $clog2(num_requesters)
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         cfg_write,
  input  cfg_addr_e                    cfg_addr,
  input  logic [CFG_DATA_WIDTH-1:0]    cfg_wdata,
  input  logic [index_width-1:0]       lowest_prio_index,
  output logic [grant_count_width-1:0] grant_allowed,
  output logic                         enable_priority_update,
  output logic [CFG_DATA_WIDTH-1:0]    cfg_rdata
);

  // Requested limit after clamping to the largest supported value
  logic [grant_count_width-1:0] grant_allowed_clamped;

  assign grant_allowed_clamped = (cfg_wdata > CFG_DATA_WIDTH'(max_grants)) ?
                                 grant_count_width'(max_grants) :
                                 grant_count_width'(cfg_wdata);

  // Writes to the status address fall through and change nothing
  always_ff @(posedge clk) begin
    if (reset) begin
      grant_allowed          <= grant_count_width'(max_grants);
      enable_priority_update <= 1'b1;
    end else if (cfg_write) begin
      case (cfg_addr)
        CFG_GRANT_ALLOWED: grant_allowed <= grant_allowed_clamped;
        CFG_PRIO_UPDATE:   enable_priority_update <= cfg_wdata[0];
        default: ;
      endcase
    end
  end

  // Readback, fields sit in the low bits and the rest reads zero
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      CFG_GRANT_ALLOWED: cfg_rdata = CFG_DATA_WIDTH'(grant_allowed);
      CFG_PRIO_UPDATE:   cfg_rdata = CFG_DATA_WIDTH'(enable_priority_update);
      CFG_STATUS:        cfg_rdata = CFG_DATA_WIDTH'(lowest_prio_index);
      default:           cfg_rdata = '0;
    endcase
  end

endmodule

/* source/arb_subsystem_top.sv */
//--------------------------------------------------------------------------
// Needs num_requesters >= 2 and 2 <= max_grants <= num_requesters
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module arb_subsystem_top
  import arb_pkg::*;
#(
  parameter int num_requesters = 8,
  parameter int max_grants = 3,
  localparam int grant_count_width = $clog2(max_grants + 1),
  localparam int index_width = $clog2(num_requesters),
  localparam int select_width = $clog2(num_requesters + 1)
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [num_requesters-1:0]                 request,
  input  logic                                      cfg_write,
  input  cfg_addr_e                                 cfg_addr,
  input  logic [CFG_DATA_WIDTH-1:0]                 cfg_wdata,
  input  logic [select_width-1:0]                   stat_select,
  input  logic                                      stat_clear,
  output logic [num_requesters-1:0]                 grant,
  output logic [max_grants-1:0][num_requesters-1:0] grant_ordered,
  output logic [grant_count_width-1:0]              grant_count,
  output logic [CFG_DATA_WIDTH-1:0]                 cfg_rdata,
  output logic [STAT_WIDTH-1:0]                     stat_count
);

  // Steering from the register block into the arbiter
  logic [grant_count_width-1:0] grant_allowed;
  logic                         enable_priority_update;
  // Marker position fed back for status readback
  logic [index_width-1:0]       lowest_prio_index;

  arb_config #(
    .num_requesters(num_requesters),
    .max_grants(max_grants)
  ) u_config (
    .clk(clk),
    .reset(reset),
    .cfg_write(cfg_write),
    .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata),
    .lowest_prio_index(lowest_prio_index),
    .grant_allowed(grant_allowed),
    .enable_priority_update(enable_priority_update),
    .cfg_rdata(cfg_rdata)
  );

  arb_multi_rr #(
    .num_requesters(num_requesters),
    .max_grants(max_grants)
  ) u_arbiter (
    .clk(clk),
    .reset(reset),
    .enable_priority_update(enable_priority_update),
    .request(request),
    .grant_allowed(grant_allowed),
    .grant(grant),
    .grant_ordered(grant_ordered),
    .grant_count(grant_count),
    .lowest_prio_index(lowest_prio_index)
  );

  // Statistics watch the same grant vector that leaves the top level
  grant_stats #(
    .num_requesters(num_requesters)
  ) u_stats (
    .clk(clk),
    .reset(reset),
    .grant(grant),
    .stat_clear(stat_clear),
    .stat_select(stat_select),
    .stat_count(stat_count)
  );

endmodule

/* source/grant_stats.sv */
//--------------------------------------------------------------------------
// Counters wrap, a clear in the same cycle as a grant takes precedence
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module grant_stats
  import arb_pkg::*;
#(
  parameter int num_requesters = 8,
  localparam int select_width = $clog2(num_requesters + 1),
  localparam int index_width = $clog2(num_requesters)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [num_requesters-1:0] grant,
  input  logic                      stat_clear,
  input  logic [select_width-1:0]   stat_select,
  output logic [STAT_WIDTH-1:0]     stat_count
);

  // One grant counter per requester
  logic [num_requesters-1:0][STAT_WIDTH-1:0] counters;

  //------------------------------------------------------------------------
  // Counting
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset || stat_clear) begin
      counters <= '0;
    end else begin
      for (int i = 0; i < num_requesters; i++) begin
        if (grant[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  //------------------------------------------------------------------------
  // Read port
  //------------------------------------------------------------------------

  // Selects past the last requester read as zero
  assign stat_count = (stat_select < select_width'(num_requesters)) ?
                      counters[index_width'(stat_select)] : '0;

endmodule

/* sources.f */
common/arb_pkg.sv
arbiter/enc_priority_dynamic.sv
arbiter/arb_multi_rr.sv
source/arb_config.sv
source/grant_stats.sv
source/arb_subsystem_top.sv
bench/arb_assertions.sv
bench/arb_tb.sv
